// File: hdl/st_pkg.sv
package st_pkg;

	typedef logic [23:1] addr_t;	// cpu word address, a0 is implied by the strobes
	typedef logic [15:0] data_t;
	typedef logic [2:0]  ipl_t;	// active low, as the 68000 samples it

	// ram size code from the system control word
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_cfg_e;

	localparam int DEV_COUNT = 6;

	// bit position of each peripheral in io_sel / io_rdata
	typedef enum logic [2:0] {
		DEV_MMU  = 3'd0,
		DEV_VREG = 3'd1,
		DEV_DMA  = 3'd2,
		DEV_PSG  = 3'd3,
		DEV_MFP  = 3'd4,
		DEV_ACIA = 3'd5
	} dev_e;

	localparam int SLOT_W = 2;
	localparam logic [SLOT_W-1:0] SLOT_VIDEO = 2'd0;
	localparam logic [SLOT_W-1:0] SLOT_CPU   = 2'd1;

	localparam int BERR_LIMIT = 7;	// cpu slots w/o dtack, fits the 3 bit counter

	// memory map, byte addresses, ends are exclusive
	localparam logic [23:0] RAM_END        = 24'he00000;
	localparam logic [23:0] RAM_WR_END     = 24'h400000;	// st ram up to 4MB
	localparam logic [23:0] RAM_WR_END_8M  = 24'h800000;
	localparam logic [23:0] RAM_WR_END_14M = 24'he00000;
	localparam logic [23:0] TOS256_BASE    = 24'he00000;
	localparam logic [23:0] TOS256_END     = 24'he40000;
	localparam logic [23:0] CART_BASE      = 24'hfa0000;
	localparam logic [23:0] CART_END       = 24'hfc0000;
	localparam logic [23:0] TOS192_BASE    = 24'hfc0000;
	localparam logic [23:0] TOS192_END     = 24'hff0000;
	localparam logic [23:0] IO_PAGE        = 24'hff0000;
	localparam logic [23:0] IACK_BASE      = 24'hfffff0;

	// io windows on the low 16 address bits: base and size in address bits
	localparam logic [15:0] IO_WIN_BASE [DEV_COUNT] =
		'{16'h8000, 16'h8200, 16'h8600, 16'h8800, 16'hfa00, 16'hfc00};
	localparam int IO_WIN_BITS [DEV_COUNT] = '{1, 7, 4, 8, 6, 8};

	// data lanes per device
	localparam logic [DEV_COUNT-1:0] DEV_UPPER_LANE = (6'b1 << DEV_PSG) | (6'b1 << DEV_ACIA);
	localparam logic [DEV_COUNT-1:0] DEV_LOWER_LANE = (6'b1 << DEV_MMU) | (6'b1 << DEV_MFP);
	localparam logic [DEV_COUNT-1:0] DEV_WORD_LANE  = (6'b1 << DEV_VREG) | (6'b1 << DEV_DMA);

	// ipl encodings, ipl0 stays high on the st
	localparam ipl_t IPL_MFP  = 3'b001;	// level 6
	localparam ipl_t IPL_VBI  = 3'b011;	// level 4
	localparam ipl_t IPL_HBI  = 3'b101;	// level 2
	localparam ipl_t IPL_NONE = 3'b111;

	localparam logic [7:0] VEC_VBI = 8'h1c;
	localparam logic [7:0] VEC_HBI = 8'h1a;

	// level presented on a3..a1 in an iack cycle
	localparam logic [2:0] ACK_LEVEL_MFP = 3'd6;
	localparam logic [2:0] ACK_LEVEL_VBI = 3'd4;
	localparam logic [2:0] ACK_LEVEL_HBI = 3'd2;

endpackage

// File: hdl/bus_slot_arbiter.sv
module bus_slot_arbiter (
	input  logic           clk_8,
	input  logic           pll_locked,
	input  logic           cpu_as_n,
	input  logic           cpu_rw,
	input  logic           cpu_uds_n,
	input  logic           cpu_lds_n,
	input  st_pkg::addr_t  cpu_addr,
	input  st_pkg::data_t  cpu_dout,
	input  logic           bus_req,	// other bus master wants the cpu halted
	input  logic           cpu_ram_rd,	// already qualified by as_valid
	input  logic           cpu_ram_wr,
	input  st_pkg::addr_t  video_addr,
	input  logic           video_read,
	output logic           as_valid,
	output st_pkg::addr_t  ram_addr,
	output st_pkg::data_t  ram_wdata,
	output logic           ram_we_n,
	output logic           ram_oe_n,
	output logic           ram_uds_n,
	output logic           ram_lds_n
);
	import st_pkg::*;

	logic [SLOT_W-1:0] slot;	// 0 video, 1 cpu, 2/3 idle
	logic video_cycle;
	logic cpu_cycle;

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot     <= SLOT_VIDEO;
			as_valid <= 1'b0;
		end else begin
			slot <= slot + 1'b1;	// free running, wraps after slot 3
			// strobe taken at the end of the video slot, live for the cpu slot only
			as_valid <= (slot == SLOT_VIDEO) && !cpu_as_n && !bus_req;
		end
	end

	assign video_cycle = (slot == SLOT_VIDEO);
	assign cpu_cycle   = (slot == SLOT_CPU);

	// video owns the ram address in slot 0, cpu otherwise
	assign ram_addr  = video_cycle ? video_addr : cpu_addr;
	assign ram_wdata = cpu_dout;

	assign ram_oe_n = video_cycle ? !video_read :
		(cpu_cycle ? !cpu_ram_rd : 1'b1);
	assign ram_we_n = !cpu_ram_wr;

	// video always fetches full words
	assign ram_uds_n = video_cycle ? 1'b0 : cpu_uds_n;
	assign ram_lds_n = video_cycle ? 1'b0 : cpu_lds_n;

	// ram writes only ever come out of a valid cpu slot
	a_we_in_cpu_slot : assert property (
		@(posedge clk_8) disable iff (!pll_locked)
		!as_valid |-> ram_we_n
	) else $error("ram write outside the cpu slot");

endmodule

// File: hdl/st_addr_decode.sv
module st_addr_decode (
	input  st_pkg::addr_t                 cpu_addr,
	input  logic                          cpu_rw,
	input  logic                          as_valid,
	input  st_pkg::mem_cfg_e              mem_cfg,
	output logic                          cpu_ram_rd,
	output logic                          cpu_ram_wr,
	output logic                          cpu2mem,	// ram or rom, not qualified
	output logic [st_pkg::DEV_COUNT-1:0]  io_sel,
	output logic                          io_hit,
	output logic                          ack_vbi,
	output logic                          ack_hbi,
	output logic                          ack_mfp
);
	import st_pkg::*;

	logic [23:0] byte_addr;
	logic [23:0] wr_end;	// top of writable ram for this config
	logic [15:0] io_off;
	logic ram_rd_ok;
	logic ram_wr_ok;
	logic cpu2rom;
	logic cpu2io;
	logic cpu2iack;

	assign byte_addr = {cpu_addr, 1'b0};
	assign io_off    = byte_addr[15:0];

	// reads see the whole 14MB no matter how much is fitted
	assign ram_rd_ok = byte_addr < RAM_END;

	assign wr_end = (mem_cfg == MEM_14M) ? RAM_WR_END_14M :
		(mem_cfg == MEM_8M) ? RAM_WR_END_8M : RAM_WR_END;
	assign ram_wr_ok = byte_addr < wr_end;

	// tos 256k, cartridge and tos 192k
	assign cpu2rom = ((byte_addr >= TOS256_BASE) && (byte_addr < TOS256_END)) ||
		((byte_addr >= CART_BASE) && (byte_addr < CART_END)) ||
		((byte_addr >= TOS192_BASE) && (byte_addr < TOS192_END));

	assign cpu2mem  = ram_rd_ok || (cpu_rw && cpu2rom);	// rom writes fall through
	assign cpu2io   = byte_addr >= IO_PAGE;
	assign cpu2iack = byte_addr >= IACK_BASE;

	assign cpu_ram_rd = as_valid && cpu_rw && cpu2mem;
	assign cpu_ram_wr = as_valid && !cpu_rw && ram_wr_ok;

	// iack level sits on a3..a1
	assign ack_mfp = as_valid && cpu2iack && (cpu_addr[3:1] == ACK_LEVEL_MFP);
	assign ack_vbi = as_valid && cpu2iack && (cpu_addr[3:1] == ACK_LEVEL_VBI);
	assign ack_hbi = as_valid && cpu2iack && (cpu_addr[3:1] == ACK_LEVEL_HBI);

	always_comb begin
		logic [DEV_COUNT-1:0] sel;
		sel = '0;
		if (as_valid && cpu2io && !cpu2iack) begin
			for (int d = 0; d < DEV_COUNT; d++) begin
				// compare above the window size only
				if ((io_off >> IO_WIN_BITS[d]) == (IO_WIN_BASE[d] >> IO_WIN_BITS[d]))
					sel[d] = 1'b1;
			end
		end
		// mfp supplies its own vector in a level 6 iack
		sel[DEV_MFP] = sel[DEV_MFP] | ack_mfp;
		// windows in the io page must not overlap
		assert ($onehot0(sel)) else $error("io windows overlap at %h", byte_addr);
		io_sel = sel;
	end

	// anything outside memory that still ends the cycle
	assign io_hit = (|io_sel) || ack_vbi || ack_hbi || ack_mfp;

endmodule

// File: hdl/dtack_berr_gen.sv
module dtack_berr_gen (
	input  logic clk_8,
	input  logic pll_locked,
	input  logic as_valid,
	input  logic cpu_as_n,
	input  logic bus_req,
	input  logic cpu2mem,
	input  logic io_hit,
	input  logic cpu_clr_berr,
	output logic cpu_dtack_n,
	output logic cpu_berr
);
	import st_pkg::*;

	logic [2:0] timeout;	// unanswered cpu slots
	logic dtack;

	// other bus master halts the cpu by holding off dtack
	assign dtack       = as_valid && (cpu2mem || io_hit) && !bus_req;
	assign cpu_dtack_n = !dtack;

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			timeout <= '0;
		end else if (timeout == 3'(BERR_LIMIT)) begin
			if (cpu_clr_berr)
				timeout <= '0;	// cpu has taken the exception
		end else if (cpu_as_n || bus_req) begin
			timeout <= '0;	// idle or halted
		end else if (as_valid && !dtack) begin
			timeout <= timeout + 3'd1;	// once per cpu slot
		end
	end

	// held until cleared
	assign cpu_berr = (timeout == 3'(BERR_LIMIT));

	// cpu must clear berr before starting another cycle
	a_dtack_vs_berr : assert property (
		@(posedge clk_8) disable iff (!pll_locked)
		!(!cpu_dtack_n && cpu_berr)
	) else $error("dtack and bus error active together");

endmodule

// File: hdl/irq_priority.sv
module irq_priority (
	input  logic          clk_8,
	input  logic          pll_locked,
	input  logic          vsync,
	input  logic          hsync,
	input  logic          mfp_irq,	// level, held by the mfp until acked
	input  logic          ack_vbi,
	input  logic          ack_hbi,
	input  logic          ack_mfp,
	output st_pkg::ipl_t  cpu_ipl,
	output logic [7:0]    autovector,
	output logic          mfp_iack
);
	import st_pkg::*;

	// bit 1 vbi, bit 0 hbi throughout
	logic [1:0] blank_in;
	logic [1:0] blank_ack;
	logic [1:0] blank_meta;
	logic [1:0] blank_sync;
	logic [1:0] blank_prev;
	logic [1:0] blank_rise;
	logic [1:0] blank_pend;

	assign blank_in  = {vsync, hsync};
	assign blank_ack = {ack_vbi, ack_hbi};

	assign blank_rise = blank_sync & ~blank_prev;	// single cycle event

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			blank_meta <= '0;
			blank_sync <= '0;
			blank_prev <= '0;
			blank_pend <= '0;
		end else begin
			blank_meta <= blank_in;	// sync comes from the video clock domain
			blank_sync <= blank_meta;
			blank_prev <= blank_sync;
			// ack wins over a new edge in the same cycle
			blank_pend <= (blank_pend | blank_rise) & ~blank_ack;
		end
	end

	// mfp over vbi over hbi
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			cpu_ipl <= IPL_NONE;
		else if (mfp_irq)
			cpu_ipl <= IPL_MFP;
		else if (blank_pend[1])
			cpu_ipl <= IPL_VBI;
		else if (blank_pend[0])
			cpu_ipl <= IPL_HBI;
		else
			cpu_ipl <= IPL_NONE;
	end

	/*
	 * the st wires vbi and hbi as autovectored, but the cpu here always runs
	 * a vectored iack, so the glue answers those two levels with the
	 * matching autovector number itself
	 */
	assign autovector = ack_vbi ? VEC_VBI :
		(ack_hbi ? VEC_HBI : 8'h00);

	assign mfp_iack = ack_mfp;	// mfp puts its vector on the bus

endmodule

// File: hdl/io_read_mux.sv
module io_read_mux (
	input  logic [st_pkg::DEV_COUNT-1:0]   io_sel,
	input  st_pkg::data_t [st_pkg::DEV_COUNT-1:0] io_rdata,
	input  logic [7:0]                     autovector,
	input  logic                           cpu2mem,
	input  st_pkg::data_t                  ram_rdata,
	output st_pkg::data_t                  cpu_din
);
	import st_pkg::*;

	data_t io_word;

	// 8 bit devices deliver their byte on bits 7..0
	always_comb begin
		io_word = '0;
		for (int d = 0; d < DEV_COUNT; d++) begin
			if (io_sel[d]) begin	// unselected devices may drive junk
				if (DEV_UPPER_LANE[d])
					io_word = io_word | {io_rdata[d][7:0], 8'h00};	// d15..d8
				else if (DEV_LOWER_LANE[d])
					io_word = io_word | {8'h00, io_rdata[d][7:0]};
				else if (DEV_WORD_LANE[d])
					io_word = io_word | io_rdata[d];
			end
		end
		io_word = io_word | {8'h00, autovector};	// zero outside an iack
	end

	assign cpu_din = cpu2mem ? ram_rdata : io_word;

endmodule

// File: hdl/st_bus_glue.sv
module st_bus_glue (
	input  logic                                  clk_8,
	input  logic                                  pll_locked,
	input  st_pkg::mem_cfg_e                      mem_cfg,
	input  logic                                  bus_req,
	// 68000 side
	input  st_pkg::addr_t                         cpu_addr,
	input  logic                                  cpu_as_n,
	input  logic                                  cpu_uds_n,
	input  logic                                  cpu_lds_n,
	input  logic                                  cpu_rw,
	input  st_pkg::data_t                         cpu_dout,
	input  logic                                  cpu_clr_berr,
	output st_pkg::data_t                         cpu_din,
	output logic                                  cpu_dtack_n,
	output logic                                  cpu_berr,
	output st_pkg::ipl_t                          cpu_ipl,
	// shared st ram
	output st_pkg::addr_t                         ram_addr,
	output st_pkg::data_t                         ram_wdata,
	output logic                                  ram_we_n,
	output logic                                  ram_oe_n,
	output logic                                  ram_uds_n,
	output logic                                  ram_lds_n,
	input  st_pkg::data_t                         ram_rdata,
	input  st_pkg::addr_t                         video_addr,
	input  logic                                  video_read,
	// peripherals
	output logic [st_pkg::DEV_COUNT-1:0]          io_sel,
	output st_pkg::data_t                         io_wdata,
	output logic                                  mfp_iack,
	input  st_pkg::data_t [st_pkg::DEV_COUNT-1:0] io_rdata,
	input  logic                                  mfp_irq,
	input  logic                                  vsync,
	input  logic                                  hsync
);

	logic as_valid;	// cpu strobe seen in the cpu slot
	logic cpu_ram_rd;
	logic cpu_ram_wr;
	logic cpu2mem;
	logic io_hit;
	logic ack_vbi;
	logic ack_hbi;
	logic ack_mfp;
	logic [7:0] autovector;

	assign io_wdata = cpu_dout;	// peripherals share the cpu write data

	bus_slot_arbiter i_arbiter (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.cpu_as_n   (cpu_as_n),
		.cpu_rw     (cpu_rw),
		.cpu_uds_n  (cpu_uds_n),
		.cpu_lds_n  (cpu_lds_n),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.bus_req    (bus_req),
		.cpu_ram_rd (cpu_ram_rd),
		.cpu_ram_wr (cpu_ram_wr),
		.video_addr (video_addr),
		.video_read (video_read),
		.as_valid   (as_valid),
		.ram_addr   (ram_addr),
		.ram_wdata  (ram_wdata),
		.ram_we_n   (ram_we_n),
		.ram_oe_n   (ram_oe_n),
		.ram_uds_n  (ram_uds_n),
		.ram_lds_n  (ram_lds_n)
	);

	st_addr_decode i_decode (
		.cpu_addr   (cpu_addr),
		.cpu_rw     (cpu_rw),
		.as_valid   (as_valid),
		.mem_cfg    (mem_cfg),
		.cpu_ram_rd (cpu_ram_rd),
		.cpu_ram_wr (cpu_ram_wr),
		.cpu2mem    (cpu2mem),
		.io_sel     (io_sel),
		.io_hit     (io_hit),
		.ack_vbi    (ack_vbi),
		.ack_hbi    (ack_hbi),
		.ack_mfp    (ack_mfp)
	);

	dtack_berr_gen i_dtack (
		.clk_8        (clk_8),
		.pll_locked   (pll_locked),
		.as_valid     (as_valid),
		.cpu_as_n     (cpu_as_n),
		.bus_req      (bus_req),
		.cpu2mem      (cpu2mem),
		.io_hit       (io_hit),
		.cpu_clr_berr (cpu_clr_berr),
		.cpu_dtack_n  (cpu_dtack_n),
		.cpu_berr     (cpu_berr)
	);

	irq_priority i_irq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.vsync      (vsync),
		.hsync      (hsync),
		.mfp_irq    (mfp_irq),
		.ack_vbi    (ack_vbi),
		.ack_hbi    (ack_hbi),
		.ack_mfp    (ack_mfp),
		.cpu_ipl    (cpu_ipl),
		.autovector (autovector),
		.mfp_iack   (mfp_iack)
	);

	io_read_mux i_rdmux (
		.io_sel     (io_sel),
		.io_rdata   (io_rdata),
		.autovector (autovector),
		.cpu2mem    (cpu2mem),
		.ram_rdata  (ram_rdata),
		.cpu_din    (cpu_din)
	);

endmodule

// File: test/tb_st_ref.svh
// 16 bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// ram and rom content never written, folds every address bit
function automatic data_t mem_fill(input addr_t w);
	return 16'(w) ^ 16'(w >> 11) ^ 16'ha5c3;
endfunction

// fixed read data per peripheral
function automatic data_t periph_word(input int d);
	return {8'h30 + 8'(d), 8'hc0 + 8'(d)};
endfunction

function automatic logic ram_writable(input logic [23:0] a, input mem_cfg_e cfg);
	logic [23:0] top;
	top = 24'h400000;	// st ram limit for the small configs
	if (cfg == MEM_8M)
		top = 24'h800000;
	if (cfg == MEM_14M)
		top = 24'he00000;
	return a < top;
endfunction

function automatic logic [5:0] decode_select(input logic [23:0] a);
	logic [15:0] o;
	o = a[15:0];
	if (a >= 24'hfffff0)
		return (a[3:1] == 3'd6) ? 6'b010000 : 6'b000000;	// level 6 iack goes to mfp
	if (a < 24'hff0000)
		return 6'b000000;
	if (o >= 16'h8000 && o < 16'h8002) return 6'b000001;
	if (o >= 16'h8200 && o < 16'h8280) return 6'b000010;
	if (o >= 16'h8600 && o < 16'h8610) return 6'b000100;
	if (o >= 16'h8800 && o < 16'h8900) return 6'b001000;
	if (o >= 16'hfa00 && o < 16'hfa40) return 6'b010000;
	if (o >= 16'hfc00 && o < 16'hfd00) return 6'b100000;
	return 6'b000000;	// hole in the io page
endfunction

function automatic logic dtack_expected(input logic [23:0] a, input logic rw);
	logic rom;
	rom = (a >= 24'he00000 && a < 24'he40000) || (a >= 24'hfa0000 && a < 24'hff0000);
	if (a < 24'he00000)
		return 1'b1;	// ram answers even when not fitted
	if (rw && rom)
		return 1'b1;
	if (a >= 24'hfffff0)
		return a[3:1] == 3'd2 || a[3:1] == 3'd4 || a[3:1] == 3'd6;
	return decode_select(a) != 6'b0;
endfunction

function automatic data_t read_data(input logic [23:0] a, input data_t mem_word);
	logic [5:0] s;
	data_t p;
	s = decode_select(a);
	if (a < 24'hff0000)
		return mem_word;
	if (a >= 24'hfffff0 && a[3:1] == 3'd4) return 16'h001c;
	if (a >= 24'hfffff0 && a[3:1] == 3'd2) return 16'h001a;
	for (int d = 0; d < 6; d++) begin
		p = periph_word(d);
		if (s[d] && (d == 3 || d == 5)) return {p[7:0], 8'h00};	// psg, acia
		if (s[d] && (d == 0 || d == 4)) return {8'h00, p[7:0]};	// mmu, mfp
		if (s[d]) return p;
	end
	return 16'h0000;
endfunction

// File: test/tb_st_bus_glue.sv
module tb_st_bus_glue;
	timeunit 1ns;
	timeprecision 100ps;
	import st_pkg::*;
	`include "tb_st_ref.svh"

	logic clk_8 = 1'b0;
	logic pll_locked, bus_req, cpu_as_n, cpu_uds_n, cpu_lds_n, cpu_rw, cpu_clr_berr;
	mem_cfg_e mem_cfg;
	addr_t cpu_addr, ram_addr, video_addr;
	data_t cpu_dout, cpu_din, ram_wdata, ram_rdata, io_wdata;
	logic cpu_dtack_n, cpu_berr, ram_we_n, ram_oe_n, ram_uds_n, ram_lds_n, video_read;
	ipl_t cpu_ipl;
	logic [DEV_COUNT-1:0] io_sel;
	data_t [DEV_COUNT-1:0] io_rdata;
	logic mfp_iack, mfp_irq, vsync, hsync;

	data_t ram_mem [addr_t];	// ram model
	data_t exp_mem [addr_t];	// what reads should return
	data_t ram_word;	// byte merge in the ram model
	int wr_count = 0;
	int errors = 0;
	logic [15:0] lfsr = 16'd46;
	logic we_seen, exp_dtack, exp_we, exp_iack, obs_dtack, obs_berr, obs_iack;
	logic exp_oe, obs_oe;	// ram output enable in the dtack cycle
	logic [5:0] exp_sel, obs_sel;
	data_t exp_din, obs_din;
	data_t exp_wdata, obs_wdata;
	logic [23:0] ram_a [6];
	logic [31:0] r;
	event access_done;

	st_bus_glue i_dut (.*);

	always #2 clk_8 = ~clk_8;

	always @(posedge clk_8) begin
		if (!ram_we_n) begin
			ram_word = ram_mem.exists(ram_addr) ? ram_mem[ram_addr] : mem_fill(ram_addr);
			if (!ram_uds_n)
				ram_word[15:8] = ram_wdata[15:8];
			if (!ram_lds_n)
				ram_word[7:0] = ram_wdata[7:0];
			ram_mem[ram_addr] = ram_word;
			wr_count++;	// wakes the read side
		end
	end
	always @(ram_addr or wr_count)
		ram_rdata = ram_mem.exists(ram_addr) ? ram_mem[ram_addr] : mem_fill(ram_addr);
	always @(negedge clk_8)
		if (!ram_we_n) we_seen = 1'b1;

	task automatic report(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);	// one step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic drive(input logic [23:0] a, input logic rw, input data_t wd);
		data_t old;
		old = exp_mem.exists(a[23:1]) ? exp_mem[a[23:1]] : mem_fill(a[23:1]);
		exp_dtack = dtack_expected(a, rw);
		exp_sel   = decode_select(a);
		exp_we    = !rw && ram_writable(a, mem_cfg);
		exp_iack  = a >= 24'hfffff0 && a[3:1] == 3'd6;
		exp_oe    = rw && exp_dtack && a < 24'hff0000;	// memory reads only
		exp_wdata = wd;
		exp_din   = read_data(a, old);
		if (exp_we)	// only the strobed bytes change
			exp_mem[a[23:1]] = {cpu_uds_n ? old[15:8] : wd[15:8],
				cpu_lds_n ? old[7:0] : wd[7:0]};
		cpu_addr = a[23:1];
		cpu_rw   = rw;
		cpu_dout = wd;
		we_seen  = 1'b0;
		cpu_as_n = 1'b0;
	endtask

	task automatic clear_berr();
		int n;
		n = 0;
		cpu_clr_berr = 1'b1;
		while (cpu_berr && n < 16) begin
			@(posedge clk_8);
			#1;
			n++;
		end
		cpu_clr_berr = 1'b0;
		if (cpu_berr)
			report("bus error did not clear");
	endtask

	task automatic wait_end();
		int n;
		n = 0;
		while (cpu_dtack_n && !cpu_berr && n < 64) begin
			@(negedge clk_8);	// outputs settled mid cycle
			n++;
		end
		if (cpu_dtack_n && !cpu_berr) begin
			$display("timeout: no dtack or bus error within 64 cycles");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			obs_dtack = !cpu_dtack_n;
			obs_berr  = cpu_berr;
			obs_din   = cpu_din;
			obs_sel   = io_sel;
			obs_iack  = mfp_iack;
			obs_oe    = !ram_oe_n;
			obs_wdata = io_wdata;
			@(posedge clk_8);
			#1;
			cpu_as_n = 1'b1;
			if (obs_berr)
				clear_berr();
			-> access_done;	// bus idle until the next edge
			@(posedge clk_8);
			#1;
		end
	endtask

	task automatic access(input logic [23:0] a, input logic rw, input data_t wd);
		drive(a, rw, wd);
		wait_end();
	endtask

	task automatic wait_ipl(input ipl_t want);
		int n;
		n = 0;
		while (cpu_ipl !== want && n < 5) begin
			@(posedge clk_8);
			#1;
			n++;
		end
		if (cpu_ipl !== want)
			report($sformatf("ipl %b, expected %b", cpu_ipl, want));
	endtask

	// compares each finished access against the reference
	always @(access_done) begin
		if (obs_dtack !== exp_dtack || obs_berr !== !exp_dtack)
			report($sformatf("%h dtack %b berr %b", {cpu_addr, 1'b0}, obs_dtack, obs_berr));
		if (obs_sel !== exp_sel)
			report($sformatf("%h io_sel %b, expected %b", {cpu_addr, 1'b0}, obs_sel, exp_sel));
		if (exp_dtack && cpu_rw && obs_din !== exp_din)
			report($sformatf("%h read %h, expected %h", {cpu_addr, 1'b0}, obs_din, exp_din));
		if (obs_iack !== exp_iack)
			report("mfp_iack wrong");
		if (we_seen !== exp_we)
			report($sformatf("%h ram write strobe %b", {cpu_addr, 1'b0}, we_seen));
		if (obs_oe !== exp_oe)
			report($sformatf("%h ram_oe_n %b", {cpu_addr, 1'b0}, !obs_oe));
		if (!cpu_rw && obs_wdata !== exp_wdata)
			report($sformatf("%h io_wdata %h, expected %h", {cpu_addr, 1'b0},
				obs_wdata, exp_wdata));
	end

	initial begin
		pll_locked = 1'b0;
		bus_req = 1'b0;
		cpu_as_n = 1'b1;
		cpu_uds_n = 1'b0;
		cpu_lds_n = 1'b0;
		cpu_rw = 1'b1;
		cpu_clr_berr = 1'b0;
		cpu_addr = '0;
		cpu_dout = '0;
		mem_cfg = MEM_512K;
		video_addr = '0;
		video_read = 1'b1;
		mfp_irq = 1'b0;
		vsync = 1'b0;
		hsync = 1'b0;
		for (int d = 0; d < DEV_COUNT; d++)
			io_rdata[d] = periph_word(d);
		repeat (16) @(posedge clk_8);
		#1;
		pll_locked = 1'b1;
		repeat (4) @(posedge clk_8);
		#1;
		for (int c = 0; c < 6; c++) begin
			mem_cfg = mem_cfg_e'(c);
			for (int i = 0; i < 6; i++) begin
				take_bits(23, r);
				ram_a[i] = {23'(r % 32'h700000), 1'b0};
				take_bits(2, r);
				cpu_uds_n = (r[1:0] == 2'd1);	// lower byte, upper byte or word
				cpu_lds_n = (r[1:0] == 2'd2);
				take_bits(16, r);
				access(ram_a[i], 1'b0, r[15:0]);
			end
			cpu_uds_n = 1'b0;	// word reads
			cpu_lds_n = 1'b0;
			for (int i = 0; i < 6; i++)
				access(ram_a[i], 1'b1, '0);
		end
		access(24'he00100, 1'b1, '0);	// tos 256k
		access(24'hfa0200, 1'b1, '0);	// cartridge
		access(24'hfc0010, 1'b1, '0);
		access(24'hfe0000, 1'b1, '0);
		access(24'he00100, 1'b0, 16'h1234);	// rom write, bus error
		access(24'hff8000, 1'b1, '0);
		access(24'hff8240, 1'b1, '0);
		access(24'hff8604, 1'b1, '0);
		access(24'hff8800, 1'b1, '0);
		access(24'hff8802, 1'b0, 16'h5500);
		access(24'hfffa10, 1'b1, '0);
		access(24'hfffc02, 1'b1, '0);
		access(24'hff8a00, 1'b1, '0);	// blitter hole
		hsync = 1'b1;
		wait_ipl(IPL_HBI);
		vsync = 1'b1;
		wait_ipl(IPL_VBI);
		hsync = 1'b0;
		vsync = 1'b0;
		mfp_irq = 1'b1;
		wait_ipl(IPL_MFP);
		mfp_irq = 1'b0;
		wait_ipl(IPL_VBI);
		access(24'hfffff8, 1'b1, '0);	// level 4 iack
		wait_ipl(IPL_HBI);
		access(24'hfffff4, 1'b1, '0);	// level 2
		wait_ipl(IPL_NONE);
		mfp_irq = 1'b1;
		access(24'hfffffc, 1'b1, '0);	// level 6
		mfp_irq = 1'b0;
		bus_req = 1'b1;
		drive(ram_a[0], 1'b1, '0);
		repeat (40) begin
			@(negedge clk_8);
			if (!cpu_dtack_n || cpu_berr)
				report("access ended while bus_req was high");
		end
		@(posedge clk_8);
		#1;
		bus_req = 1'b0;
		wait_end();
		repeat (4) @(posedge clk_8);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: st_bus_glue.f
+incdir+test
hdl/st_pkg.sv
hdl/bus_slot_arbiter.sv
hdl/st_addr_decode.sv
hdl/dtack_berr_gen.sv
hdl/irq_priority.sv
hdl/io_read_mux.sv
hdl/st_bus_glue.sv
test/tb_st_bus_glue.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_st_bus_glue -Mdir obj_dir -f st_bus_glue.f
./obj_dir/Vtb_st_bus_glue > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	exit 1
fi
exit 0
